//--- design/msg_handler_pkg.sv
package msg_handler_pkg;

  ////////////////////////////////
  // received header layout
  ////////////////////////////////
  localparam int HDR_BYTES = 12;

  // byte offsets, 16-bit fields are big endian
  localparam int OFS_SRC_HI   = 0;
  localparam int OFS_DST_HI   = 2;
  localparam int OFS_SIZE_HI  = 4;
  localparam int OFS_TYPE     = 6;
  localparam int OFS_OPERAND  = 7;
  localparam int OFS_PARA1_HI = 8;
  localparam int OFS_PARA2_HI = 10;

  ////////////////////////////////
  // message types
  ////////////////////////////////
  localparam logic [7:0] TYPE_PING = 8'h01;
  localparam logic [7:0] TYPE_CALC = 8'h0e;

  // set in a request that expects no answer
  localparam int TYPE_NOREPLY_BIT = 4;
  localparam logic [7:0] REPLY_FLAG = 8'h80;

  // calculator operations
  localparam logic [7:0] OP_ADD = 8'h10;
  localparam logic [7:0] OP_SUB = 8'h20;
  localparam logic [7:0] OP_MUL = 8'h30;

  // reply sizing
  localparam int REPLY_IDX_W = 4;
  localparam logic [REPLY_IDX_W-1:0] PING_REPLY_BYTES = 4'd8;
  localparam logic [REPLY_IDX_W-1:0] CALC_REPLY_BYTES = 4'd9;

endpackage

//--- design/frame_receiver.sv
module frame_receiver #(
  parameter int ADDR_W     = 11,
  parameter int GAP_CYCLES = 16
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_rready,
  input  logic [7:0]        i_rdata,
  input  logic              i_frame_done,
  output logic              o_rreq,
  output logic              o_wr_en,
  output logic [ADDR_W-1:0] o_wr_addr,
  output logic [7:0]        o_wr_data,
  output logic              o_frame_ready,
  output logic [ADDR_W-1:0] o_frame_len
);

  localparam int GAP_W = $clog2(GAP_CYCLES + 1);
  localparam logic [ADDR_W-1:0] LEN_MAX = '1;

  typedef enum logic {ST_RX, ST_HOLD} state_t;

  state_t            state;
  logic [ADDR_W-1:0] byte_cnt;
  logic [GAP_W-1:0]  gap_cnt;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state         <= ST_RX;
      o_rreq        <= 1'b0;
      o_wr_en       <= 1'b0;
      o_frame_ready <= 1'b0;
      o_frame_len   <= '0;
      byte_cnt      <= '0;
      gap_cnt       <= '0;
    end else begin
      o_wr_en       <= 1'b0;
      o_frame_ready <= 1'b0;
      case (state)
        ST_RX: begin
          if (o_rreq) begin
            // byte taken at this edge, next cycle is the gap cycle
            o_rreq  <= 1'b0;
            gap_cnt <= '0;
            if (byte_cnt != LEN_MAX) begin
              o_wr_en  <= 1'b1;
              byte_cnt <= byte_cnt + 1'b1;
            end
          end else if (i_rready) begin
            o_rreq  <= 1'b1;
            gap_cnt <= '0;
          end else if (byte_cnt != '0) begin
            // idle line after at least one byte
            if (gap_cnt == GAP_W'(GAP_CYCLES - 1)) begin
              o_frame_ready <= 1'b1;
              o_frame_len   <= byte_cnt;
              state         <= ST_HOLD;
            end else begin
              gap_cnt <= gap_cnt + 1'b1;
            end
          end
        end
        ST_HOLD: begin
          // fifo untouched until the frame is handled
          if (i_frame_done) begin
            state    <= ST_RX;
            byte_cnt <= '0;
            gap_cnt  <= '0;
          end
        end
        default: state <= ST_RX;
      endcase
    end
  end

  // write data captured with the pop
  always_ff @(posedge i_clk) begin
    if (o_rreq) begin
      o_wr_addr <= byte_cnt;
      o_wr_data <= i_rdata;
    end
  end

  // every pop needs a gap cycle so the fifo flag can settle
  assert property (@(posedge i_clk) disable iff (i_rst) o_rreq |=> !o_rreq);

endmodule

//--- design/frame_buffer.sv
module frame_buffer #(
  parameter int ADDR_W = 11
) (
  input  logic              i_clk,
  input  logic              i_wr_en,
  input  logic [ADDR_W-1:0] i_wr_addr,
  input  logic [7:0]        i_wr_data,
  input  logic [ADDR_W-1:0] i_rd_addr,
  output logic [7:0]        o_rd_data
);

  logic [7:0] mem [2**ADDR_W];

  // write port, receiver side
  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // registered read, parser side
  always_ff @(posedge i_clk) begin
    o_rd_data <= mem[i_rd_addr];
  end

endmodule

//--- design/header_parser.sv
module header_parser #(
  parameter int ADDR_W = 11
) (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_frame_ready,
  input  logic [ADDR_W-1:0]  i_frame_len,
  input  logic [7:0]         i_rd_data,
  output logic [ADDR_W-1:0]  o_rd_addr,
  output logic               o_hdr_valid,
  output logic               o_hdr_short,
  output logic [15:0]        o_src_addr,
  output logic [15:0]        o_dst_addr,
  output logic [7:0]         o_msg_type,
  output logic [7:0]         o_operand,
  output logic signed [15:0] o_para1,
  output logic signed [15:0] o_para2
);

  logic busy;
  // low while the address is presented, high when the byte is back
  logic phase;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy        <= 1'b0;
      phase       <= 1'b0;
      o_rd_addr   <= '0;
      o_hdr_valid <= 1'b0;
      o_hdr_short <= 1'b0;
    end else begin
      o_hdr_valid <= 1'b0;
      if (i_frame_ready) begin
        busy        <= 1'b1;
        phase       <= 1'b0;
        o_rd_addr   <= '0;
        o_hdr_short <= int'(i_frame_len) < msg_handler_pkg::HDR_BYTES;
      end else if (busy) begin
        phase <= ~phase;
        if (phase) begin
          if (int'(o_rd_addr) == msg_handler_pkg::HDR_BYTES - 1) begin
            busy        <= 1'b0;
            o_hdr_valid <= 1'b1;
          end else begin
            o_rd_addr <= o_rd_addr + 1'b1;
          end
        end
      end
    end
  end

  ////////////////////////////////
  // field capture by offset
  ////////////////////////////////
  always_ff @(posedge i_clk) begin
    if (busy && phase) begin
      case (int'(o_rd_addr))
        msg_handler_pkg::OFS_SRC_HI:       o_src_addr[15:8] <= i_rd_data;
        msg_handler_pkg::OFS_SRC_HI + 1:   o_src_addr[7:0]  <= i_rd_data;
        msg_handler_pkg::OFS_DST_HI:       o_dst_addr[15:8] <= i_rd_data;
        msg_handler_pkg::OFS_DST_HI + 1:   o_dst_addr[7:0]  <= i_rd_data;
        msg_handler_pkg::OFS_TYPE:         o_msg_type       <= i_rd_data;
        msg_handler_pkg::OFS_OPERAND:      o_operand        <= i_rd_data;
        msg_handler_pkg::OFS_PARA1_HI:     o_para1[15:8]    <= i_rd_data;
        msg_handler_pkg::OFS_PARA1_HI + 1: o_para1[7:0]     <= i_rd_data;
        msg_handler_pkg::OFS_PARA2_HI:     o_para2[15:8]    <= i_rd_data;
        msg_handler_pkg::OFS_PARA2_HI + 1: o_para2[7:0]     <= i_rd_data;
        // size field not needed, the reply size is fixed per type
        default: ;
      endcase
    end
  end

endmodule

//--- design/command_engine.sv
module command_engine (
  input  logic                                  i_clk,
  input  logic                                  i_rst,
  input  logic                                  i_hdr_valid,
  input  logic                                  i_hdr_short,
  input  logic [15:0]                           i_src_addr,
  input  logic [15:0]                           i_dst_addr,
  input  logic [7:0]                            i_msg_type,
  input  logic [7:0]                            i_operand,
  input  logic signed [15:0]                    i_para1,
  input  logic signed [15:0]                    i_para2,
  input  logic [msg_handler_pkg::REPLY_IDX_W-1:0] i_tx_idx,
  input  logic                                  i_tx_finished,
  output logic                                  o_tx_start,
  output logic [msg_handler_pkg::REPLY_IDX_W-1:0] o_tx_len,
  output logic [7:0]                            o_tx_byte,
  output logic                                  o_frame_done,
  output logic                                  o_done
);

  logic signed [15:0] calc_result;
  logic               stage_valid;
  logic               stage_reply;
  logic               stage_calc;
  logic               is_ping;
  logic               is_calc;
  logic               no_reply;

  assign is_ping  = i_msg_type == msg_handler_pkg::TYPE_PING;
  assign is_calc  = i_msg_type == msg_handler_pkg::TYPE_CALC;
  assign no_reply = i_hdr_short | i_msg_type[msg_handler_pkg::TYPE_NOREPLY_BIT] |
                    ~(is_ping | is_calc);

  // low 16 bits only
  always_ff @(posedge i_clk) begin
    if (i_hdr_valid) begin
      case (i_operand)
        msg_handler_pkg::OP_ADD: calc_result <= i_para1 + i_para2;
        msg_handler_pkg::OP_SUB: calc_result <= i_para1 - i_para2;
        msg_handler_pkg::OP_MUL: calc_result <= i_para1 * i_para2;
        default:                 calc_result <= '0;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      stage_valid <= 1'b0;
      stage_reply <= 1'b0;
      stage_calc  <= 1'b0;
      o_tx_start  <= 1'b0;
      o_tx_len    <= '0;
      o_done      <= 1'b0;
    end else begin
      stage_valid <= i_hdr_valid;
      o_tx_start  <= 1'b0;
      if (i_hdr_valid) begin
        stage_reply <= ~no_reply;
        stage_calc  <= is_calc;
      end
      if (stage_valid && stage_reply) begin
        o_tx_start <= 1'b1;
        o_tx_len   <= stage_calc ? msg_handler_pkg::CALC_REPLY_BYTES :
                                   msg_handler_pkg::PING_REPLY_BYTES;
      end
      // frame ends after decode or after the last reply byte
      o_done <= (stage_valid & ~stage_reply) | i_tx_finished;
    end
  end

  assign o_frame_done = o_done;

  ////////////////////////////////
  // reply byte map
  ////////////////////////////////
  always_comb begin
    case (i_tx_idx)
      4'd0:    o_tx_byte = i_dst_addr[15:8];
      4'd1:    o_tx_byte = i_dst_addr[7:0];
      4'd2:    o_tx_byte = i_src_addr[15:8];
      4'd3:    o_tx_byte = i_src_addr[7:0];
      4'd4:    o_tx_byte = 8'h00;
      4'd5:    o_tx_byte = stage_calc ? 8'h02 : 8'h01;
      4'd6:    o_tx_byte = i_msg_type | msg_handler_pkg::REPLY_FLAG;
      4'd7:    o_tx_byte = stage_calc ? calc_result[15:8] : 8'h00;
      4'd8:    o_tx_byte = calc_result[7:0];
      default: o_tx_byte = 8'h00;
    endcase
  end

endmodule

//--- design/frame_transmitter.sv
module frame_transmitter (
  input  logic                                  i_clk,
  input  logic                                  i_rst,
  input  logic                                  i_tx_start,
  input  logic [msg_handler_pkg::REPLY_IDX_W-1:0] i_tx_len,
  input  logic [7:0]                            i_tx_byte,
  input  logic                                  i_wready,
  output logic [msg_handler_pkg::REPLY_IDX_W-1:0] o_tx_idx,
  output logic                                  o_tx_finished,
  output logic                                  o_wvalid,
  output logic [7:0]                            o_wdata
);

  logic                                  active;
  logic [msg_handler_pkg::REPLY_IDX_W-1:0] tx_len;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      active        <= 1'b0;
      o_tx_idx      <= '0;
      o_tx_finished <= 1'b0;
      o_wvalid      <= 1'b0;
    end else begin
      o_wvalid <= 1'b0;
      // the last byte leaves active low behind it
      o_tx_finished <= o_wvalid & ~active;
      if (i_tx_start) begin
        active   <= 1'b1;
        o_tx_idx <= '0;
      end else if (active && !o_wvalid && i_wready) begin
        o_wvalid <= 1'b1;
        o_tx_idx <= o_tx_idx + 1'b1;
        if (o_tx_idx == tx_len - 1'b1) begin
          active <= 1'b0;
        end
      end
    end
  end

  // byte and length registers
  always_ff @(posedge i_clk) begin
    if (i_tx_start) begin
      tx_len <= i_tx_len;
    end
    if (active && !o_wvalid && i_wready) begin
      o_wdata <= i_tx_byte;
    end
  end

  assert property (@(posedge i_clk) disable iff (i_rst) o_wvalid |-> $past(i_wready));

  // engine only asks for one of the two reply shapes
  assert property (@(posedge i_clk) disable iff (i_rst)
    i_tx_start |-> (i_tx_len == msg_handler_pkg::PING_REPLY_BYTES ||
                    i_tx_len == msg_handler_pkg::CALC_REPLY_BYTES));

endmodule

//--- design/msg_handler.sv
module msg_handler #(
  parameter int ADDR_W     = 11,
  parameter int GAP_CYCLES = 16
) (
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_rready,
  input  logic [7:0] i_rdata,
  output logic       o_rreq,
  input  logic       i_wready,
  output logic       o_wvalid,
  output logic [7:0] o_wdata,
  output logic       o_done
);

  // receive path
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  logic [7:0]        wr_data;
  logic              frame_ready;
  logic [ADDR_W-1:0] frame_len;
  logic              frame_done;
  logic [ADDR_W-1:0] rd_addr;
  logic [7:0]        rd_data;

  // decoded header
  logic               hdr_valid;
  logic               hdr_short;
  logic [15:0]        src_addr;
  logic [15:0]        dst_addr;
  logic [7:0]         msg_type;
  logic [7:0]         operand;
  logic signed [15:0] para1;
  logic signed [15:0] para2;

  // reply path
  logic                                  tx_start;
  logic [msg_handler_pkg::REPLY_IDX_W-1:0] tx_len;
  logic [msg_handler_pkg::REPLY_IDX_W-1:0] tx_idx;
  logic [7:0]                            tx_byte;
  logic                                  tx_finished;

  frame_receiver #(.ADDR_W(ADDR_W), .GAP_CYCLES(GAP_CYCLES)) receiver_inst (
    .i_clk(i_clk), .i_rst(i_rst), .i_rready(i_rready), .i_rdata(i_rdata),
    .i_frame_done(frame_done), .o_rreq(o_rreq), .o_wr_en(wr_en),
    .o_wr_addr(wr_addr), .o_wr_data(wr_data), .o_frame_ready(frame_ready),
    .o_frame_len(frame_len)
  );

  frame_buffer #(.ADDR_W(ADDR_W)) buffer_inst (
    .i_clk(i_clk), .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
    .i_rd_addr(rd_addr), .o_rd_data(rd_data)
  );

  header_parser #(.ADDR_W(ADDR_W)) parser_inst (
    .i_clk(i_clk), .i_rst(i_rst), .i_frame_ready(frame_ready), .i_frame_len(frame_len),
    .i_rd_data(rd_data), .o_rd_addr(rd_addr), .o_hdr_valid(hdr_valid),
    .o_hdr_short(hdr_short), .o_src_addr(src_addr), .o_dst_addr(dst_addr),
    .o_msg_type(msg_type), .o_operand(operand), .o_para1(para1), .o_para2(para2)
  );

  command_engine engine_inst (
    .i_clk(i_clk), .i_rst(i_rst), .i_hdr_valid(hdr_valid), .i_hdr_short(hdr_short),
    .i_src_addr(src_addr), .i_dst_addr(dst_addr), .i_msg_type(msg_type),
    .i_operand(operand), .i_para1(para1), .i_para2(para2), .i_tx_idx(tx_idx),
    .i_tx_finished(tx_finished), .o_tx_start(tx_start), .o_tx_len(tx_len),
    .o_tx_byte(tx_byte), .o_frame_done(frame_done), .o_done(o_done)
  );

  frame_transmitter transmitter_inst (
    .i_clk(i_clk), .i_rst(i_rst), .i_tx_start(tx_start), .i_tx_len(tx_len),
    .i_tx_byte(tx_byte), .i_wready(i_wready), .o_tx_idx(tx_idx),
    .o_tx_finished(tx_finished), .o_wvalid(o_wvalid), .o_wdata(o_wdata)
  );

endmodule

//--- testbench/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int CLK_PERIOD = 100,
  parameter int RST_CYCLES = 4
) (
  output logic o_clk,
  output logic o_rst
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    o_clk = 1'b0;
    forever #(CLK_PERIOD / 2) o_clk = ~o_clk;
  end

  // released on a falling edge, away from the sampling edge
  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst = 1'b0;
  end

endmodule

//--- testbench/tb_msg_handler.sv
module tb_msg_handler;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 2000;

  logic       clk;
  logic       rst;
  logic       rready = 1'b0;
  logic [7:0] rdata = 8'h00;
  logic       wready = 1'b1;
  logic       rreq;
  logic       wvalid;
  logic [7:0] wdata;
  logic       done;

  logic [7:0]  fifo_q[$];
  logic [7:0]  sink_q[$];
  logic [7:0]  frame_q[$];
  int          fifo_rd = 0;
  logic        rreq_at_edge;
  logic        wready_at_edge;
  logic [31:0] rng_state = 32'h3ad1;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          done_count = 0;
  int          frames_sent = 0;
  int          pace_violations = 0;

  tb_clock_gen clock_gen_inst (.o_clk(clk), .o_rst(rst));

  msg_handler msg_handler_inst (
    .i_clk(clk), .i_rst(rst), .i_rready(rready), .i_rdata(rdata), .o_rreq(rreq),
    .i_wready(wready), .o_wvalid(wvalid), .o_wdata(wdata), .o_done(done)
  );

  //////////////////////////////
  // fifo model and reply sink
  //////////////////////////////
  always @(posedge clk) begin
    rreq_at_edge   <= rreq;
    wready_at_edge <= wready;
  end

  // head byte leaves after the edge that took it
  always @(negedge clk) begin
    if (rreq_at_edge && fifo_rd < fifo_q.size()) begin
      fifo_rd++;
    end
    rready = fifo_rd < fifo_q.size();
    rdata  = (fifo_rd < fifo_q.size()) ? fifo_q[fifo_rd] : 8'h00;
  end

  always @(negedge clk) begin
    if (wvalid) begin
      sink_q.push_back(wdata);
      if (!wready_at_edge) begin
        $display("FAIL %0t: o_wvalid raised without i_wready at the previous edge", $time);
        pace_violations++;
      end
    end
  end

  always @(negedge clk) begin
    if (done) begin
      done_count++;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // low 16 bits of the signed result
  // an unknown operand gives zero
  function automatic logic [15:0] calc_expected(input logic [7:0] op, input logic [15:0] a,
                                                input logic [15:0] b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic signed [31:0] full;
    sa = {{16{a[15]}}, a};
    sb = {{16{b[15]}}, b};
    case (op)
      8'h10:   full = sa + sb;
      8'h20:   full = sa - sb;
      8'h30:   full = sa * sb;
      default: full = 32'sd0;
    endcase
    return full[15:0];
  endfunction

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string msg);
    checks++;
    if (actual !== expected) begin
      $display("FAIL %0t: %s, got %0h, expected %0h", $time, msg, actual, expected);
      errors++;
    end
  endtask

  // 12-byte header with big endian fields
  task automatic build_frame(input logic [15:0] src, input logic [15:0] dst,
                             input logic [7:0] mtype, input logic [7:0] op,
                             input logic [15:0] p1, input logic [15:0] p2);
    logic [95:0] hdr;
    hdr = {src, dst, 16'h0004, mtype, op, p1, p2};
    frame_q.delete();
    for (int i = 0; i < 12; i++) begin
      frame_q.push_back(hdr[95 - 8 * i -: 8]);
    end
  endtask

  // queues the frame and waits for o_done while optionally pacing i_wready
  task automatic run_frame(input bit pace, output int base);
    int          cycles;
    int          stretch;
    bit          seen;
    logic [31:0] r;
    base = sink_q.size();
    @(posedge clk);
    foreach (frame_q[i]) begin
      fifo_q.push_back(frame_q[i]);
    end
    frames_sent++;
    cycles  = 0;
    stretch = 0;
    seen    = 1'b0;
    while (!seen && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
      if (pace) begin
        if (stretch == 0) begin
          r       = next_random();
          wready  = r[0];
          stretch = 1 + int'(r[3:1]);
        end
        stretch--;
      end
      seen = done;
    end
    wready = 1'b1;
    if (!seen) begin
      $display("timeout: no o_done within %0d cycles after a frame was queued", TIMEOUT_CYCLES);
      errors++;
    end
  endtask

  task automatic check_reply(input int base, input logic [71:0] expected, input int nbytes,
                             input string name);
    check_eq(32'(sink_q.size() - base), 32'(nbytes), {name, " reply length"});
    for (int i = 0; i < nbytes && base + i < sink_q.size(); i++) begin
      check_eq(32'(sink_q[base + i]), 32'(expected[8 * (nbytes - 1 - i) +: 8]),
               $sformatf("%s reply byte %0d", name, i));
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    tests++;
    if (errors == start_errors) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - start_errors);
    end
  endtask

  task automatic send_calc(input logic [7:0] op, input bit pace, input string name);
    logic [31:0] r;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] src;
    logic [15:0] dst;
    int          base;
    r   = next_random();
    a   = r[15:0];
    b   = r[31:16];
    r   = next_random();
    src = r[15:0];
    dst = r[31:16];
    build_frame(src, dst, 8'h0e, op, a, b);
    run_frame(pace, base);
    check_reply(base, {dst, src, 16'h0002, 8'h8e, calc_expected(op, a, b)}, 9, name);
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////
  task automatic reset_values();
    int e0;
    e0 = errors;
    check_eq(32'(rreq), 32'd0, "o_rreq after reset");
    check_eq(32'(wvalid), 32'd0, "o_wvalid after reset");
    check_eq(32'(done), 32'd0, "o_done after reset");
    report_test("reset_values", e0);
  endtask

  task automatic ping_reply();
    int e0;
    int base;
    e0 = errors;
    build_frame(16'h0a01, 16'h0b02, 8'h01, 8'h00, 16'h0000, 16'h0000);
    run_frame(1'b0, base);
    check_reply(base, {8'h00, 16'h0b02, 16'h0a01, 16'h0001, 8'h81, 8'h00}, 8, "ping");
    report_test("ping_reply", e0);
  endtask

  task automatic calc_operations();
    int e0;
    e0 = errors;
    send_calc(8'h10, 1'b0, "calc add");
    send_calc(8'h20, 1'b0, "calc sub");
    send_calc(8'h30, 1'b0, "calc mul");
    send_calc(8'h40, 1'b0, "calc unknown operand");
    report_test("calc_operations", e0);
  endtask

  // frames that end with o_done and no reply bytes
  task automatic silent_frames();
    int e0;
    int base;
    e0 = errors;
    build_frame(16'h0c03, 16'h0d04, 8'h13, 8'h10, 16'h0001, 16'h0002);
    run_frame(1'b0, base);
    check_eq(32'(sink_q.size() - base), 32'd0, "reply bytes for type 8'h13");
    build_frame(16'h0e05, 16'h0f06, 8'h01, 8'h00, 16'h0000, 16'h0000);
    while (frame_q.size() > 6) begin
      void'(frame_q.pop_back());
    end
    run_frame(1'b0, base);
    check_eq(32'(sink_q.size() - base), 32'd0, "reply bytes for a 6-byte frame");
    report_test("silent_frames", e0);
  endtask

  task automatic paced_reply();
    int e0;
    e0 = errors;
    send_calc(8'h30, 1'b1, "paced calc mul");
    send_calc(8'h20, 1'b1, "paced calc sub");
    report_test("paced_reply", e0);
  endtask

  task automatic back_to_back_frames();
    int e0;
    int base;
    e0 = errors;
    build_frame(16'h1111, 16'h2222, 8'h01, 8'h00, 16'h0000, 16'h0000);
    run_frame(1'b0, base);
    check_reply(base, {8'h00, 16'h2222, 16'h1111, 16'h0001, 8'h81, 8'h00}, 8, "first ping");
    send_calc(8'h10, 1'b0, "second calc");
    report_test("back_to_back_frames", e0);
  endtask

  initial begin
    int cycles;
    cycles = 0;
    while (rst !== 1'b0 && cycles < 100) begin
      @(negedge clk);
      cycles++;
    end
    if (rst !== 1'b0) begin
      $display("timeout: reset was never released");
      errors++;
    end
    reset_values();
    ping_reply();
    calc_operations();
    silent_frames();
    paced_reply();
    back_to_back_frames();
    // away from the falling edge where the counters move
    @(posedge clk);
    check_eq(32'(done_count), 32'(frames_sent), "o_done pulses against frames sent");
    check_eq(32'(pace_violations), 32'd0, "o_wvalid without i_wready");
    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- msg_handler.f
design/msg_handler_pkg.sv
design/frame_receiver.sv
design/frame_buffer.sv
design/header_parser.sv
design/command_engine.sv
design/frame_transmitter.sv
design/msg_handler.sv
testbench/tb_clock_gen.sv
testbench/tb_msg_handler.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run tb_msg_handler with verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f msg_handler.f --top-module tb_msg_handler \
  -o tb_msg_handler > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_msg_handler > sim.log 2>&1 || { cat sim.log; echo "simulator error"; exit 1; }

cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "result: fail"; exit 1; } || echo "result: pass"
